//--- rtl/clic_pkg.sv
// Shared types, register map and field positions for the CLIC subsystem
// Also holds the APB phase enum
`default_nettype none

package clic_pkg;

  // Interrupt level, 0 means never taken
  typedef logic [7:0] level_t;
  localparam int LEVEL_W = $bits(level_t);

  // Core privilege level, only U and M are modelled
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // APB address and data words
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // APB transfer phase as seen by the slave
  typedef enum logic {
    IDLE,
    ACCESS
  } apb_state_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Per-source control words, one word per source
  localparam apb_addr_t REG_CTL_BASE = 12'h000;
  // Core state
  localparam apb_addr_t REG_STATUS   = 12'h100;
  localparam apb_addr_t REG_THRESH   = 12'h104;
  localparam apb_addr_t REG_MIL      = 12'h108;
  localparam apb_addr_t REG_MPIL     = 12'h10C;
  // Next interrupt, read only
  localparam apb_addr_t REG_NXTI     = 12'h110;

  // Control word fields
  localparam int CTL_LEVEL_LSB   = 0;
  localparam int CTL_IE_BIT      = 8;
  localparam int CTL_SHV_BIT     = 9;
  localparam int CTL_IP_BIT      = 10;

  // Status word fields
  localparam int STATUS_MIE_BIT  = 0;
  localparam int STATUS_PRIV_LSB = 1;

  // Next interrupt word, id sits in the low bits
  localparam int NXTI_PEND_BIT   = 31;
  localparam int NXTI_LEVEL_LSB  = 8;

endpackage

`default_nettype wire

//--- rtl/clic_ifs.sv
// Interfaces between the CLIC stages
// Selected interrupt bundle and core state bundle
`default_nettype none

// Arbiter result towards the interrupt controller
interface clic_irq_if import clic_pkg::*; #(
  parameter int ID_WIDTH = 3
);
  // Registered selection
  logic                irq;
  logic [ID_WIDTH-1:0] id;
  level_t              level;
  logic                shv;
  // Selection before its register, feeds wake-up
  logic                irq_comb;
  level_t              level_comb;

  modport drive (output irq, id, level, shv, irq_comb, level_comb);
  modport user  (input  irq, id, level, shv, irq_comb, level_comb);
endinterface

// Core state as the controller sees it
interface clic_core_if import clic_pkg::*;;
  logic     mie;
  privlvl_t priv;
  level_t   thresh;
  level_t   mil;
  level_t   mpil;

  modport drive (output mie, priv, thresh, mil, mpil);
  modport user  (input  mie, priv, thresh, mil, mpil);
endinterface

`default_nettype wire

//--- rtl/clic_apb_regs.sv
// APB slave with per-source control words and core state registers
`default_nettype none

module clic_apb_regs import clic_pkg::*; #(
  parameter int NUM_IRQ  = 8,
  parameter int ID_WIDTH = 3
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // APB slave
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  apb_addr_t                   paddr_i,
  input  apb_data_t                   pwdata_i,
  output apb_data_t                   prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // Per-source fields to the arbiter
  output level_t [NUM_IRQ-1:0]        src_level_o,
  output logic   [NUM_IRQ-1:0]        src_ie_o,
  output logic   [NUM_IRQ-1:0]        src_shv_o,
  output logic   [NUM_IRQ-1:0]        src_ip_o,
  // Next interrupt result from the controller
  input  logic                        nxti_pending_i,
  input  logic   [ID_WIDTH-1:0]       nxti_id_i,
  input  level_t                      nxti_level_i,
  // Core state
  clic_core_if.drive                  core
);

  apb_state_t           state_q;
  apb_addr_t            ctl_off;
  logic                 ctl_hit;
  logic [ID_WIDTH-1:0]  ctl_idx;
  logic                 acc;
  logic                 addr_err;
  logic                 ro_err;
  logic                 wr_en;
  apb_data_t            rdata;

  level_t [NUM_IRQ-1:0] level_q;
  logic   [NUM_IRQ-1:0] ie_q;
  logic   [NUM_IRQ-1:0] shv_q;
  logic   [NUM_IRQ-1:0] ip_q;
  logic                 mie_q;
  privlvl_t             priv_q;
  level_t               thresh_q;
  level_t               mil_q;
  level_t               mpil_q;

  ////////////////////////////////////////////////////////////
  // Phase tracking and decode
  ////////////////////////////////////////////////////////////

  // Setup cycle arms the access phase for the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= (psel_i && !penable_i) ? ACCESS : IDLE;
    end
  end

  assign acc = psel_i && penable_i && (state_q == ACCESS);

  // Word aligned hit inside the control word window
  assign ctl_off = paddr_i - REG_CTL_BASE;
  assign ctl_hit = (ctl_off[1:0] == 2'b00) && (int'(ctl_off[11:2]) < NUM_IRQ);
  assign ctl_idx = ctl_off[ID_WIDTH+1:2];

  // Read mux, also flags unmapped addresses
  always_comb begin
    rdata    = '0;
    addr_err = 1'b0;
    if (ctl_hit) begin
      rdata[CTL_LEVEL_LSB +: LEVEL_W] = level_q[ctl_idx];
      rdata[CTL_IE_BIT]               = ie_q[ctl_idx];
      rdata[CTL_SHV_BIT]              = shv_q[ctl_idx];
      rdata[CTL_IP_BIT]               = ip_q[ctl_idx];
    end else begin
      case (paddr_i)
        REG_STATUS: begin
          rdata[STATUS_MIE_BIT]       = mie_q;
          rdata[STATUS_PRIV_LSB +: 2] = priv_q;
        end
        REG_THRESH: rdata[LEVEL_W-1:0] = thresh_q;
        REG_MIL:    rdata[LEVEL_W-1:0] = mil_q;
        REG_MPIL:   rdata[LEVEL_W-1:0] = mpil_q;
        REG_NXTI: begin
          rdata[NXTI_PEND_BIT]             = nxti_pending_i;
          rdata[NXTI_LEVEL_LSB +: LEVEL_W] = nxti_level_i;
          rdata[ID_WIDTH-1:0]              = nxti_id_i;
        end
        default: addr_err = 1'b1;
      endcase
    end
  end

  // NXTI is read only
  assign ro_err = pwrite_i && (paddr_i == REG_NXTI);
  assign wr_en  = acc && pwrite_i && !addr_err && !ro_err;

  assign prdata_o  = rdata;
  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = acc && (addr_err || ro_err);

  ////////////////////////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q  <= '0;
      ie_q     <= '0;
      shv_q    <= '0;
      ip_q     <= '0;
      mie_q    <= 1'b0;
      priv_q   <= PRIV_LVL_M;
      thresh_q <= '0;
      mil_q    <= '0;
      mpil_q   <= '0;
    end else if (wr_en) begin
      if (ctl_hit) begin
        level_q[ctl_idx] <= pwdata_i[CTL_LEVEL_LSB +: LEVEL_W];
        ie_q[ctl_idx]    <= pwdata_i[CTL_IE_BIT];
        shv_q[ctl_idx]   <= pwdata_i[CTL_SHV_BIT];
        ip_q[ctl_idx]    <= pwdata_i[CTL_IP_BIT];
      end else begin
        case (paddr_i)
          REG_STATUS: begin
            mie_q  <= pwdata_i[STATUS_MIE_BIT];
            // Anything other than M encoding falls back to U
            priv_q <= (pwdata_i[STATUS_PRIV_LSB +: 2] == 2'(PRIV_LVL_M)) ?
                      PRIV_LVL_M : PRIV_LVL_U;
          end
          REG_THRESH: thresh_q <= pwdata_i[LEVEL_W-1:0];
          REG_MIL:    mil_q    <= pwdata_i[LEVEL_W-1:0];
          REG_MPIL:   mpil_q   <= pwdata_i[LEVEL_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign src_level_o = level_q;
  assign src_ie_o    = ie_q;
  assign src_shv_o   = shv_q;
  assign src_ip_o    = ip_q;

  assign core.mie    = mie_q;
  assign core.priv   = priv_q;
  assign core.thresh = thresh_q;
  assign core.mil    = mil_q;
  assign core.mpil   = mpil_q;

endmodule

`default_nettype wire

//--- rtl/clic_arbiter.sv
// Priority arbiter over all interrupt sources
// Combinational winner plus one register stage
`default_nettype none

module clic_arbiter import clic_pkg::*; #(
  parameter int NUM_IRQ  = 8,
  parameter int ID_WIDTH = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Level sensitive hardware sources
  input  logic   [NUM_IRQ-1:0] src_irq_i,
  // Per-source configuration
  input  level_t [NUM_IRQ-1:0] src_level_i,
  input  logic   [NUM_IRQ-1:0] src_ie_i,
  input  logic   [NUM_IRQ-1:0] src_shv_i,
  input  logic   [NUM_IRQ-1:0] src_ip_i,
  // Selected interrupt
  clic_irq_if.drive            sel
);

  logic [NUM_IRQ-1:0]  cand;
  logic                win_found;
  logic [ID_WIDTH-1:0] win_id;
  level_t              win_level;
  logic                win_shv;

  logic                irq_q;
  logic [ID_WIDTH-1:0] id_q;
  level_t              level_q;
  logic                shv_q;

  // Pending from the pin or from software, and enabled
  assign cand = (src_irq_i | src_ip_i) & src_ie_i;

  ////////////////////////////////////////////////////////////
  // Winner scan
  ////////////////////////////////////////////////////////////

  // Strict compare against a running best that starts at 0
  // Level 0 never wins, and on a tie the lower index stays
  always_comb begin
    win_found = 1'b0;
    win_id    = '0;
    win_level = '0;
    win_shv   = 1'b0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (cand[i] && (src_level_i[i] > win_level)) begin
        win_found = 1'b1;
        win_id    = ID_WIDTH'(i);
        win_level = src_level_i[i];
        win_shv   = src_shv_i[i];
      end
    end
  end

  // Register the selection towards the controller
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q   <= 1'b0;
      id_q    <= '0;
      level_q <= '0;
      shv_q   <= 1'b0;
    end else begin
      irq_q   <= win_found;
      id_q    <= win_id;
      level_q <= win_level;
      shv_q   <= win_shv;
    end
  end

  // Unregistered path is only for wake-up
  assign sel.irq_comb   = win_found;
  assign sel.level_comb = win_level;

  assign sel.irq        = irq_q;
  assign sel.id         = id_q;
  assign sel.level      = level_q;
  assign sel.shv        = shv_q;

endmodule

`default_nettype wire

//--- rtl/clic_int_controller.sv
// Interrupt controller with request, wake-up and next-interrupt logic
`default_nettype none

module clic_int_controller import clic_pkg::*; #(
  parameter int ID_WIDTH = 3
) (
  input  logic                clk,
  input  logic                rst_n,
  // From the arbiter
  clic_irq_if.user            sel,
  // Core state
  clic_core_if.user           core,
  // Request towards the core
  output logic                irq_req_o,
  output logic                irq_wu_o,
  output logic [ID_WIDTH-1:0] irq_id_o,
  output level_t              irq_level_o,
  output logic                irq_shv_o,
  // Next interrupt result, read back over APB
  output logic                nxti_pending_o,
  output logic [ID_WIDTH-1:0] nxti_id_o,
  output level_t              nxti_level_o
);

  logic                global_en;
  level_t              eff_level;
  logic                in_m_mode;

  logic                irq_q;
  logic [ID_WIDTH-1:0] id_q;
  level_t              level_q;
  logic                shv_q;

  ////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////

  // Pending flag follows the arbiter every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= sel.irq;
    end
  end

  // Attributes only load while something is pending,
  // so they keep the last winner afterwards
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_q    <= '0;
      level_q <= '0;
      shv_q   <= 1'b0;
    end else if (sel.irq) begin
      id_q    <= sel.id;
      level_q <= sel.level;
      shv_q   <= sel.shv;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request and wake-up
  ////////////////////////////////////////////////////////////

  assign in_m_mode = (core.priv == PRIV_LVL_M);

  // Lower privilege always lets M-mode interrupts through
  assign global_en = core.mie || (core.priv < PRIV_LVL_M);

  // Larger of threshold and current level
  assign eff_level = (core.thresh > core.mil) ? core.thresh : core.mil;

  // M mode compares against the effective level, U mode only needs level > 0
  assign irq_req_o = irq_q && global_en &&
                     (in_m_mode ? (level_q > eff_level) : (level_q > '0));

  // Same rule on the unregistered winner, mie ignored
  assign irq_wu_o  = sel.irq_comb &&
                     (in_m_mode ? (sel.level_comb > eff_level) : (sel.level_comb > '0));

  assign irq_id_o    = id_q;
  assign irq_level_o = level_q;
  assign irq_shv_o   = shv_q;

  ////////////////////////////////////////////////////////////
  // Next interrupt
  ////////////////////////////////////////////////////////////

  // Vectored interrupts are never handed out through nxti
  assign nxti_pending_o = irq_q &&
                          (level_q > core.mpil) &&
                          (level_q > core.thresh) &&
                          !shv_q;

  assign nxti_id_o    = id_q;
  assign nxti_level_o = level_q;

endmodule

`default_nettype wire

//--- rtl/clic_top.sv
// CLIC subsystem top level
// APB register block, arbiter and interrupt controller
`default_nettype none

module clic_top import clic_pkg::*; #(
  parameter int NUM_IRQ  = 8,
  parameter int ID_WIDTH = 3
) (
  input  logic                clk,
  input  logic                rst_n,
  // APB slave
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  apb_addr_t           paddr_i,
  input  apb_data_t           pwdata_i,
  output apb_data_t           prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // Hardware interrupt sources
  input  logic [NUM_IRQ-1:0]  irq_src_i,
  // Interrupt request towards the core
  output logic                irq_req_o,
  output logic                irq_wu_o,
  output logic [ID_WIDTH-1:0] irq_id_o,
  output level_t              irq_level_o,
  output logic                irq_shv_o
);

  level_t [NUM_IRQ-1:0] src_level;
  logic   [NUM_IRQ-1:0] src_ie;
  logic   [NUM_IRQ-1:0] src_shv;
  logic   [NUM_IRQ-1:0] src_ip;
  logic                 nxti_pending;
  logic  [ID_WIDTH-1:0] nxti_id;
  level_t               nxti_level;

  // Stage to stage bundles
  clic_irq_if #(.ID_WIDTH(ID_WIDTH)) irq_bus ();
  clic_core_if                       core_bus ();

  // Register block
  clic_apb_regs #(
    .NUM_IRQ  (NUM_IRQ),
    .ID_WIDTH (ID_WIDTH)
  ) i_apb_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .src_level_o    (src_level),
    .src_ie_o       (src_ie),
    .src_shv_o      (src_shv),
    .src_ip_o       (src_ip),
    .nxti_pending_i (nxti_pending),
    .nxti_id_i      (nxti_id),
    .nxti_level_i   (nxti_level),
    .core           (core_bus.drive)
  );

  // Winner selection
  clic_arbiter #(
    .NUM_IRQ  (NUM_IRQ),
    .ID_WIDTH (ID_WIDTH)
  ) i_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .src_irq_i   (irq_src_i),
    .src_level_i (src_level),
    .src_ie_i    (src_ie),
    .src_shv_i   (src_shv),
    .src_ip_i    (src_ip),
    .sel         (irq_bus.drive)
  );

  // Request qualification
  clic_int_controller #(
    .ID_WIDTH (ID_WIDTH)
  ) i_int_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel            (irq_bus.user),
    .core           (core_bus.user),
    .irq_req_o      (irq_req_o),
    .irq_wu_o       (irq_wu_o),
    .irq_id_o       (irq_id_o),
    .irq_level_o    (irq_level_o),
    .irq_shv_o      (irq_shv_o),
    .nxti_pending_o (nxti_pending),
    .nxti_id_o      (nxti_id),
    .nxti_level_o   (nxti_level)
  );

endmodule

`default_nettype wire

//--- bench/clic_assertions.sv
// Concurrent checks on the CLIC top level
// APB response rules and request qualification, bound into clic_top
`default_nettype none

module clic_assertions import clic_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       psel_i,
  input logic       penable_i,
  input logic       pready_i,
  input logic       pslverr_i,
  input logic       irq_req_i,
  input logic       irq_q_i,
  input apb_state_t apb_state_i
);

  // Zero wait states, the slave never stalls
  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready_i)
    else $error("pready_o dropped low");

  // Error response only in the access phase of a transfer
  a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr_i |-> (psel_i && penable_i && (apb_state_i == ACCESS)))
    else $error("pslverr_o raised outside an access cycle");

  // Request always has the registered pending flag behind it
  a_req_needs_irq: assert property (@(posedge clk) disable iff (!rst_n)
    irq_req_i |-> irq_q_i)
    else $error("irq_req_o high without a registered interrupt");

endmodule

// Controller flag is the register that gates irq_req_o
bind clic_top clic_assertions i_clic_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o),
  .irq_req_i   (irq_req_o),
  .irq_q_i     (i_int_controller.irq_q),
  .apb_state_i (i_apb_regs.state_q)
);

`default_nettype wire

//--- bench/clic_tb.sv
// Testbench for the CLIC subsystem
// Stimulus table with reference model, wake-up latency and APB error checks
`default_nettype none

module clic_tb import clic_pkg::*; ();

  localparam int NUM_IRQ    = 8;
  localparam int ID_WIDTH   = 3;
  localparam int CLK_PERIOD = 8;
  localparam int NUM_FIXED  = 8;
  localparam int NUM_RAND   = 24;
  localparam int NUM_ROWS   = NUM_FIXED + NUM_RAND;
  // Per-row budget plus room for reset and the directed sections
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

  localparam logic [1:0] PRIV_M = 2'b11;
  localparam logic [1:0] PRIV_U = 2'b00;

  // One test case with stimulus first and the expected response after it
  typedef struct {
    logic [63:0] lvl;       // Level of source i in byte i
    logic [7:0]  ie;
    logic [7:0]  shv;
    logic [7:0]  ip;
    logic [7:0]  src;
    logic        mie;
    logic [1:0]  priv;
    logic [7:0]  thresh;
    logic [7:0]  mil;
    logic [7:0]  mpil;
    logic        vld;       // A winner exists
    logic        req;
    logic        wu;
    logic [2:0]  id;
    logic [7:0]  level;
    logic        shv_o;
    logic [31:0] nxti;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  apb_addr_t           paddr;
  apb_data_t           pwdata;
  apb_data_t           prdata;
  logic                pready;
  logic                pslverr;
  logic [NUM_IRQ-1:0]  irq_src;
  logic                irq_req;
  logic                irq_wu;
  logic [ID_WIDTH-1:0] irq_id;
  level_t              irq_level;
  logic                irq_shv;

  row_t                rows [NUM_ROWS];
  logic [31:0]         rand_state;

  clic_top #(
    .NUM_IRQ  (NUM_IRQ),
    .ID_WIDTH (ID_WIDTH)
  ) i_clic_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .irq_src_i   (irq_src),
    .irq_req_o   (irq_req),
    .irq_wu_o    (irq_wu),
    .irq_id_o    (irq_id),
    .irq_level_o (irq_level),
    .irq_shv_o   (irq_shv)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the test sequence never finished", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // LCG step with the constants of the common 32-bit generator
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Setup then access with the bus left in access for back-to-back use
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    // Response has settled by mid access cycle
    #(CLK_PERIOD / 4);
    err = pslverr;
    check("pready_o", 32'(pready), 32'd1);
  endtask

  task automatic apb_idle();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = prdata;
    err  = pslverr;
    check("pready_o", 32'(pready), 32'd1);
    apb_idle();
  endtask

  task automatic write_ok(input apb_addr_t addr, input apb_data_t data);
    logic err;
    apb_write(addr, data, err);
    check($sformatf("pslverr_o @0x%0h", addr), 32'(err), 32'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic row_t predict(input row_t r);
    row_t   o;
    level_t top;
    level_t eff;
    logic   lvl_ok;
    o   = r;
    top = '0;
    // Highest level among pending and enabled sources
    for (int i = 0; i < NUM_IRQ; i++) begin
      if ((r.src[i] || r.ip[i]) && r.ie[i] && (r.lvl[8*i +: 8] > top)) begin
        top = r.lvl[8*i +: 8];
      end
    end
    o.vld   = (top != '0);
    o.level = top;
    o.id    = '0;
    o.shv_o = 1'b0;
    // Walk downwards so the lowest index with the top level remains
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (o.vld && (r.src[i] || r.ip[i]) && r.ie[i] && (r.lvl[8*i +: 8] == top)) begin
        o.id    = 3'(i);
        o.shv_o = r.shv[i];
      end
    end
    eff    = (r.thresh > r.mil) ? r.thresh : r.mil;
    lvl_ok = (r.priv == PRIV_M) ? (top > eff) : (top != '0);
    o.req  = o.vld && (r.mie || (r.priv != PRIV_M)) && lvl_ok;
    // Wake-up ignores mie
    o.wu   = o.vld && lvl_ok;
    o.nxti          = '0;
    o.nxti[31]      = o.vld && (top > r.mpil) && (top > r.thresh) && !o.shv_o;
    o.nxti[15:8]    = top;
    o.nxti[2:0]     = o.id;
    return o;
  endfunction

  function automatic row_t random_row();
    row_t        r;
    logic [31:0] a;
    for (int i = 0; i < NUM_IRQ; i++) begin
      a = next_rand();
      // Coarse levels so ties are common
      r.lvl[8*i +: 8] = {a[31:29], 5'b0};
    end
    a        = next_rand();
    r.ie     = a[7:0] | a[15:8];
    r.shv    = a[23:16] & a[31:24];
    a        = next_rand();
    r.ip     = a[7:0] & a[15:8];
    r.src    = a[23:16] & a[31:24];
    a        = next_rand();
    r.mie    = a[0];
    r.priv   = a[1] ? PRIV_M : PRIV_U;
    r.thresh = {a[31:29], 5'b0};
    r.mil    = {a[28:26], 5'b0};
    r.mpil   = {a[25:23], 5'b0};
    return predict(r);
  endfunction

  // Program one row, let it pass both register stages, then compare
  task automatic apply_row(input int n, input row_t r);
    apb_data_t rd;
    logic      err;
    @(negedge clk);
    irq_src = r.src;
    for (int i = 0; i < NUM_IRQ; i++) begin
      write_ok(REG_CTL_BASE + apb_addr_t'(4 * i),
               {21'b0, r.ip[i], r.shv[i], r.ie[i], r.lvl[8*i +: 8]});
    end
    write_ok(REG_STATUS, {29'b0, r.priv, r.mie});
    write_ok(REG_THRESH, {24'b0, r.thresh});
    write_ok(REG_MIL, {24'b0, r.mil});
    write_ok(REG_MPIL, {24'b0, r.mpil});
    apb_idle();
    // Two cycles after the last access edge
    repeat (2) @(negedge clk);
    check($sformatf("row %0d irq_req_o", n), 32'(irq_req), 32'(r.req));
    check($sformatf("row %0d irq_wu_o", n), 32'(irq_wu), 32'(r.wu));
    if (r.vld) begin
      check($sformatf("row %0d irq_id_o", n), 32'(irq_id), 32'(r.id));
      check($sformatf("row %0d irq_level_o", n), 32'(irq_level), 32'(r.level));
      check($sformatf("row %0d irq_shv_o", n), 32'(irq_shv), 32'(r.shv_o));
    end
    apb_read(REG_NXTI, rd, err);
    check($sformatf("row %0d pslverr_o", n), 32'(err), 32'd0);
    // Id and level of NXTI hold stale values without a winner
    if (r.vld) begin
      check($sformatf("row %0d nxti", n), rd, r.nxti);
    end else begin
      check($sformatf("row %0d nxti[31]", n), 32'(rd[31]), 32'(r.nxti[31]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    row_t      r;
    apb_data_t rd;
    logic      err;
    clk        = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    irq_src    = '0;
    rand_state = 32'hd9fc6ee3;

    // Tie on 0x40 goes to source 1 and the disabled 0x80 source is ignored
    rows[0] = '{64'h00000000_80404010, 8'h17, 8'h04, 8'h15, 8'h0A, 1'b1, PRIV_M,
                8'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 3'd1, 8'h40, 1'b0, 32'h80004001};
    // Effective level 0x40 masks the request
    rows[1] = '{64'h00000000_80404010, 8'h17, 8'h04, 8'h15, 8'h0A, 1'b1, PRIV_M,
                8'h20, 8'h40, 8'h00, 1'b1, 1'b0, 1'b0, 3'd1, 8'h40, 1'b0, 32'h80004001};
    // Level just above the effective level while mpil blocks nxti
    rows[2] = '{64'h00000000_80404010, 8'h17, 8'h04, 8'h15, 8'h0A, 1'b1, PRIV_M,
                8'h20, 8'h3F, 8'h40, 1'b1, 1'b1, 1'b1, 3'd1, 8'h40, 1'b0, 32'h00004001};
    // mie clear in M mode
    rows[3] = '{64'h00000000_80404010, 8'h17, 8'h04, 8'h15, 8'h0A, 1'b0, PRIV_M,
                8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 1'b1, 3'd1, 8'h40, 1'b0, 32'h80004001};
    // U mode ignores mie and the effective level
    rows[4] = '{64'h00000000_80404010, 8'h17, 8'h04, 8'h15, 8'h0A, 1'b0, PRIV_U,
                8'h80, 8'h80, 8'h00, 1'b1, 1'b1, 1'b1, 3'd1, 8'h40, 1'b0, 32'h00004001};
    // Vectored winner is never pending through nxti
    rows[5] = '{64'h00009000_80404010, 8'h37, 8'h24, 8'h35, 8'h0A, 1'b1, PRIV_M,
                8'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 3'd5, 8'h90, 1'b1, 32'h00009005};
    // Only a level 0 source and a disabled one
    rows[6] = '{64'hFF000000_00000000, 8'h40, 8'h00, 8'h00, 8'hC0, 1'b1, PRIV_M,
                8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00, 1'b0, 32'h00000000};
    // Tie between the two top sources
    rows[7] = '{64'h30300000_00000000, 8'hC0, 8'h80, 8'hC0, 8'h00, 1'b1, PRIV_M,
                8'h2F, 8'h10, 8'h2F, 1'b1, 1'b1, 1'b1, 3'd6, 8'h30, 1'b0, 32'h80003006};
    for (int k = NUM_FIXED; k < NUM_ROWS; k++) begin
      rows[k] = random_row();
    end

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check("irq_req_o", 32'(irq_req), 32'd0);
    check("irq_wu_o", 32'(irq_wu), 32'd0);
    check("irq_shv_o", 32'(irq_shv), 32'd0);
    check("pslverr_o", 32'(pslverr), 32'd0);
    // priv resets to M with mie clear
    apb_read(REG_STATUS, rd, err);
    check("prdata_o status", rd, 32'h0000_0006);

    for (int k = 0; k < NUM_ROWS; k++) begin
      apply_row(k, rows[k]);
    end

    // Wake-up follows the pin in the same cycle even with mie clear
    r = '{64'h00000000_00000010, 8'h01, 8'h00, 8'h00, 8'h00, 1'b0, PRIV_M,
          8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00, 1'b0, 32'h00000000};
    apply_row(NUM_ROWS, r);
    @(negedge clk);
    irq_src = 8'h01;
    #(CLK_PERIOD / 4);
    check("irq_wu_o", 32'(irq_wu), 32'd1);
    check("irq_req_o", 32'(irq_req), 32'd0);

    // Request follows the pin at the second rising edge
    @(negedge clk);
    irq_src = 8'h00;
    write_ok(REG_STATUS, 32'h0000_0007);
    apb_idle();
    repeat (3) @(negedge clk);
    check("irq_req_o", 32'(irq_req), 32'd0);
    irq_src = 8'h01;
    @(posedge clk);
    #(CLK_PERIOD / 4);
    check("irq_req_o edge 1", 32'(irq_req), 32'd0);
    @(posedge clk);
    #(CLK_PERIOD / 4);
    check("irq_req_o edge 2", 32'(irq_req), 32'd1);
    check("irq_id_o", 32'(irq_id), 32'd0);
    check("irq_level_o", 32'(irq_level), 32'h10);

    // Rejected transfers
    write_ok(REG_CTL_BASE, 32'h0000_0155);
    write_ok(REG_THRESH, 32'h0000_005A);
    // One word past the last source
    apb_write(12'h020, 32'h0000_07FF, err);
    check("pslverr_o @0x20", 32'(err), 32'd1);
    apb_write(12'h102, 32'h0000_00FF, err);
    check("pslverr_o @0x102", 32'(err), 32'd1);
    apb_write(REG_NXTI, 32'hFFFF_FFFF, err);
    check("pslverr_o nxti write", 32'(err), 32'd1);
    apb_idle();
    apb_read(REG_CTL_BASE, rd, err);
    check("pslverr_o ctl0 read", 32'(err), 32'd0);
    check("prdata_o ctl0", rd, 32'h0000_0155);
    apb_read(REG_THRESH, rd, err);
    check("prdata_o thresh", rd, 32'h0000_005A);
    apb_read(12'h200, rd, err);
    check("pslverr_o @0x200", 32'(err), 32'd1);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/clic_pkg.sv
rtl/clic_ifs.sv
rtl/clic_apb_regs.sv
rtl/clic_arbiter.sv
rtl/clic_int_controller.sv
rtl/clic_top.sv
bench/clic_assertions.sv
bench/clic_tb.sv

//--- Makefile
# Verilator flow for the CLIC subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run clic_tb, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f verilog.f --top-module clic_tb \
		-Mdir obj_dir -o clic_sim
	./obj_dir/clic_sim | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
